/* verification/chroni_input.txt */
# W addr data (hex) cpu write, F frame_start, S pixels blank (dec) one scanline
# E line x (dec) colour (hex) pixel of the last line, lines count from 0 in each frame
W 9000 00
W 9001 00
W 9002 01
W 9004 01
W 9005 34
W 9005 12
W 9005 cd
W 9005 ab
W 9006 00
W 9007 00
W 9008 00
W 9009 20   # display list at 0, three blank lines
W 9009 42   # text row with lms
W 9009 04
W 9009 00
W 9009 05
W 9009 00
W 9009 01   # end
W 9009 00
W 9009 01   # row text at 0x008
W 9009 81
W 9009 21   # row attributes at 0x00a
W 9009 12
W 9006 08
W 9007 04
W 9009 a5   # char 01 scan 0 under charset 01
W 9006 08
W 9007 08
W 9009 3c   # char 81 under charset 01, char 01 under charset 02
F
S 0 1
S 0 1
S 0 1
S 320 0
E 3 0 1234
E 3 1 abcd
E 3 5 1234
E 3 8 1234
E 3 10 abcd
S 320 0
S 320 0
S 320 0
S 320 0
S 320 0
S 320 0
S 320 0
S 0 1
S 0 1
W 9002 02
F
S 0 1
S 0 1
S 0 1
S 320 0
E 3 0 abcd
E 3 2 1234
E 3 6 abcd

/* filelist.f */
hdl/chroni_pkg.sv
hdl/chroni_regs.sv
hdl/chroni_vram.sv
hdl/chroni_row_buffer.sv
hdl/chroni_ctrl.sv
hdl/chroni_glyph_shifter.sv
hdl/chroni_palette.sv
hdl/chroni_top.sv
verification/chroni_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module chroni_tb -o chroni_sim
./obj_dir/chroni_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* verification/chroni_tb.sv */
`timescale 1ns/1ps

module chroni_tb;

   localparam int line_timeout = 2000;   // cycles, a text line takes about 450
   localparam int line_pixels  = 320;

   logic                   sys_clk;
   logic                   rst_n;
   logic [15:0]            cpu_addr;
   chroni_pkg::byte_t      cpu_wr_data;
   logic                   cpu_wr_en;
   logic                   frame_start;
   logic                   scanline_start;
   chroni_pkg::pix_color_t pix;
   logic                   line_done;
   logic                   line_blank;

   chroni_pkg::color_t line_pix [line_pixels];   // colours of the last rendered line
   int                 pix_count;
   int                 line_nr;                  // next line of the frame
   int                 last_line = -1;
   int                 e_checks  = 0;
   int                 lines_run = 0;

   chroni_top i_chroni_top (
      .sys_clk, .rst_n, .cpu_addr, .cpu_wr_data, .cpu_wr_en,
      .frame_start, .scanline_start, .pix, .line_done, .line_blank
   );

   initial begin
      sys_clk = 1'b0;
      forever #20 sys_clk = ~sys_clk;
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic cpu_write(input logic [15:0] addr, input chroni_pkg::byte_t data);
      @(posedge sys_clk);
      cpu_addr    <= addr;
      cpu_wr_data <= data;
      cpu_wr_en   <= 1'b1;
      @(posedge sys_clk);
      cpu_wr_en <= 1'b0;   // idle cycle keeps palette commits apart
   endtask

   task automatic start_frame();
      @(posedge sys_clk);
      frame_start <= 1'b1;
      @(posedge sys_clk);
      frame_start <= 1'b0;
      line_nr = 0;
   endtask

   // one scanline strobe, then collect pixels until line_done
   task automatic run_scanline(input int exp_pix, input int exp_blank);
      int   wait_cycles;
      logic done;
      logic blank_seen;
      wait_cycles = 0;
      done        = 1'b0;
      blank_seen  = 1'b0;
      pix_count   = 0;
      @(posedge sys_clk);
      scanline_start <= 1'b1;
      @(posedge sys_clk);
      scanline_start <= 1'b0;
      while (!done) begin
         @(negedge sys_clk);
         if (pix.valid) begin
            assert (int'(pix.x) == pix_count) else
               abort_run($sformatf("Fail %0t ns: line %0d pixel x %0d, expected %0d",
                                   $time, line_nr, pix.x, pix_count));
            if (pix_count < line_pixels) begin
               line_pix[pix_count] = pix.color;
            end
            pix_count++;
         end
         if (line_done) begin
            done       = 1'b1;
            blank_seen = line_blank;
         end else if (wait_cycles == line_timeout) begin
            abort_run($sformatf("line_done did not come for line %0d", line_nr));
         end
         wait_cycles++;
      end
      assert (pix_count == exp_pix) else
         abort_run($sformatf("Fail %0t ns: line %0d gave %0d pixels, expected %0d",
                             $time, line_nr, pix_count, exp_pix));
      assert (blank_seen == (exp_blank != 0)) else
         abort_run($sformatf("Fail %0t ns: line %0d line_blank %0b, expected %0d",
                             $time, line_nr, blank_seen, exp_blank));
      last_line = line_nr;
      line_nr++;
      lines_run++;
   endtask

   task automatic check_pixel(input int e_line, input int x, input chroni_pkg::color_t color);
      assert (e_line == last_line) else
         abort_run($sformatf("expected colour names line %0d but line %0d was rendered last",
                             e_line, last_line));
      assert (x < pix_count) else
         abort_run($sformatf("expected colour at x %0d lies past the pixels of the line", x));
      assert (line_pix[x] == color) else
         abort_run($sformatf("Fail %0t ns: line %0d pixel %0d colour %h, expected %h",
                             $time, e_line, x, line_pix[x], color));
      e_checks++;
   endtask

   task automatic run_command(input string text);
      byte   cmd;
      string rest;
      int    a;
      int    b;
      int    c;
      cmd  = text.getc(0);
      rest = text.substr(1, text.len() - 1);
      case (cmd)
         "W":
            if ($sscanf(rest, "%h %h", a, b) == 2) cpu_write(16'(a), 8'(b));
            else abort_run({"bad write line in input file: ", text});
         "F": start_frame();
         "S":
            if ($sscanf(rest, "%d %d", a, b) == 2) run_scanline(a, b);
            else abort_run({"bad scanline line in input file: ", text});
         "E":
            if ($sscanf(rest, "%d %d %h", a, b, c) == 3) check_pixel(a, b, 16'(c));
            else abort_run({"bad expected colour line in input file: ", text});
         default: abort_run({"unknown command in input file: ", text});
      endcase
   endtask

   initial begin
      int    fd;
      int    n;
      string text;
      rst_n          = 1'b0;
      cpu_addr       = '0;
      cpu_wr_data    = '0;
      cpu_wr_en      = 1'b0;
      frame_start    = 1'b0;
      scanline_start = 1'b0;
      repeat (3) @(posedge sys_clk);
      rst_n <= 1'b1;
      fd = $fopen("verification/chroni_input.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open verification/chroni_input.txt");
      end
      while (!$feof(fd)) begin
         n = $fgets(text, fd);
         // skip comments and empty lines
         if (n > 0 && text.len() > 1 && text.getc(0) != "#") begin
            run_command(text);
         end
      end
      $fclose(fd);
      if (e_checks > 0 && lines_run > 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         abort_run("input file ran no scanline or no pixel check");
      end
   end

endmodule

/* hdl/chroni_top.sv */
`timescale 1ns/1ps

module chroni_top (
   input  logic                   sys_clk,
   input  logic                   rst_n,
   input  logic [15:0]            cpu_addr,
   input  chroni_pkg::byte_t      cpu_wr_data,
   input  logic                   cpu_wr_en,
   input  logic                   frame_start,
   input  logic                   scanline_start,
   output chroni_pkg::pix_color_t pix,
   output logic                   line_done,
   output logic                   line_blank
);

   chroni_pkg::cfg_t       cfg;
   chroni_pkg::vram_wr_t   vram_wr;
   chroni_pkg::pal_wr_t    pal_wr;
   chroni_pkg::vram_addr_t vram_addr;
   chroni_pkg::byte_t      vram_data, wr_data, text_q, attr_q, glyph, attr;
   chroni_pkg::col_t       wr_col, rd_col;
   chroni_pkg::pix_x_t     glyph_x;
   chroni_pkg::pix_index_t pix_index;
   logic                   text_we, attr_we, glyph_load, shifter_busy;

   chroni_regs i_chroni_regs (
      .sys_clk, .rst_n, .cpu_addr, .cpu_wr_data, .cpu_wr_en,
      .cfg, .vram_wr, .pal_wr
   );

   chroni_vram i_chroni_vram (
      .sys_clk, .vram_wr, .rd_addr(vram_addr), .rd_data(vram_data)
   );

   chroni_row_buffer i_chroni_row_buffer (
      .sys_clk, .text_we, .attr_we, .wr_col, .wr_data, .rd_col, .text_q, .attr_q
   );

   chroni_ctrl i_chroni_ctrl (
      .sys_clk, .rst_n, .cfg, .frame_start, .scanline_start,
      .vram_addr, .vram_data,
      .text_we, .attr_we, .wr_col, .wr_data, .rd_col, .text_q, .attr_q,
      .glyph_load, .glyph, .attr, .glyph_x, .shifter_busy,
      .line_done, .line_blank
   );

   chroni_glyph_shifter i_chroni_glyph_shifter (
      .sys_clk, .rst_n, .load(glyph_load), .glyph, .attr, .base_x(glyph_x),
      .busy(shifter_busy), .pix(pix_index)
   );

   chroni_palette i_chroni_palette (
      .sys_clk, .rst_n, .pal_wr, .pix_in(pix_index), .pix
   );

endmodule

/* hdl/chroni_palette.sv */
`timescale 1ns/1ps

module chroni_palette (
   input  logic                   sys_clk,
   input  logic                   rst_n,
   input  chroni_pkg::pal_wr_t    pal_wr,
   input  chroni_pkg::pix_index_t pix_in,
   output chroni_pkg::pix_color_t pix
);

   chroni_pkg::color_t mem [2**$bits(chroni_pkg::pal_index_t)];
   chroni_pkg::color_t color_q;
   chroni_pkg::pix_x_t x_q;
   logic               valid_q;

   always_ff @(posedge sys_clk) begin
      if (pal_wr.en) begin
         mem[pal_wr.index] <= pal_wr.color;
      end
      color_q <= mem[pix_in.index];
   end

   // valid and position follow the ram read by one cycle
   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         x_q     <= '0;
      end else begin
         valid_q <= pix_in.valid;
         x_q     <= pix_in.x;
      end
   end

   assign pix = '{valid: valid_q, x: x_q, color: color_q};

endmodule

/* hdl/chroni_glyph_shifter.sv */
`timescale 1ns/1ps

module chroni_glyph_shifter (
   input  logic                   sys_clk,
   input  logic                   rst_n,
   input  logic                   load,
   input  chroni_pkg::byte_t      glyph,
   input  chroni_pkg::byte_t      attr,
   input  chroni_pkg::pix_x_t     base_x,
   output logic                   busy,
   output chroni_pkg::pix_index_t pix
);

   chroni_pkg::byte_t  bits;
   chroni_pkg::byte_t  attr_q;
   chroni_pkg::pix_x_t x;
   logic [2:0]         count;

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         busy  <= 1'b0;
         count <= '0;
      end else if (load) begin
         busy  <= 1'b1;
         count <= '0;
      end else if (busy) begin
         count <= count + 1'b1;
         if (&count) begin
            busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (load) begin
         bits   <= glyph;
         attr_q <= attr;
         x      <= base_x;
      end else if (busy) begin
         bits <= {bits[6:0], 1'b0};   // msb goes out first
         x    <= x + 1'b1;
      end
   end

   // set bit takes the low nibble
   assign pix = '{valid: busy, x: x, index: {4'h0, bits[7] ? attr_q[3:0] : attr_q[7:4]}};

endmodule

/* hdl/chroni_ctrl.sv */
`timescale 1ns/1ps

module chroni_ctrl (
   input  logic                   sys_clk,
   input  logic                   rst_n,
   input  chroni_pkg::cfg_t       cfg,
   input  logic                   frame_start,
   input  logic                   scanline_start,
   output chroni_pkg::vram_addr_t vram_addr,
   input  chroni_pkg::byte_t      vram_data,
   output logic                   text_we,
   output logic                   attr_we,
   output chroni_pkg::col_t       wr_col,
   output chroni_pkg::byte_t      wr_data,
   output chroni_pkg::col_t       rd_col,
   input  chroni_pkg::byte_t      text_q,
   input  chroni_pkg::byte_t      attr_q,
   output logic                   glyph_load,
   output chroni_pkg::byte_t      glyph,
   output chroni_pkg::byte_t      attr,
   output chroni_pkg::pix_x_t     glyph_x,
   input  logic                   shifter_busy,
   output logic                   line_done,
   output logic                   line_blank
);

   chroni_pkg::dl_state_t    dl_state;
   chroni_pkg::fetch_state_t fd_state;
   chroni_pkg::vram_addr_t   dl_ptr, row_addr, attr_addr;
   chroni_pkg::byte_t        dl_op;       // current instruction byte
   chroni_pkg::scan_t        scan, scan_left;
   chroni_pkg::col_t         col;
   logic [1:0]               lms_part;
   logic                     line_go, text_done, line_busy;

   assign line_blank = dl_op[3:0] != chroni_pkg::dl_text;
   assign line_done  = (line_go && line_blank) || text_done;
   assign text_we    = fd_state == chroni_pkg::fd_text_read && col != '0;
   assign attr_we    = fd_state == chroni_pkg::fd_attr_read && col != '0;
   assign wr_col     = col - 1'b1;   // data trails the address by a cycle
   assign wr_data    = vram_data;
   assign rd_col     = col;

   always_comb begin
      case (fd_state)
         chroni_pkg::fd_text_read: vram_addr = row_addr + chroni_pkg::vram_addr_t'(col);
         chroni_pkg::fd_attr_read: vram_addr = attr_addr + chroni_pkg::vram_addr_t'(col);
         chroni_pkg::fd_font_wait, chroni_pkg::fd_font_write:
            vram_addr = {cfg.charset[6:0] + 7'(text_q[7]), text_q[6:0], scan};
         default: vram_addr = dl_ptr;
      endcase
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         dl_state  <= chroni_pkg::dl_idle;
         {dl_ptr, row_addr, attr_addr} <= '0;
         {dl_op, scan, scan_left, lms_part, line_go} <= '0;
      end else if (frame_start) begin
         dl_state  <= chroni_pkg::dl_idle;
         dl_ptr    <= cfg.dl_addr;
         dl_op     <= '0;
         scan_left <= '0;
         line_go   <= 1'b0;
      end else begin
         line_go <= 1'b0;
         if (scanline_start) begin
            if (!line_blank && scan == chroni_pkg::scan_t'(chroni_pkg::font_rows - 1)) begin
               row_addr  <= row_addr + chroni_pkg::vram_addr_t'(chroni_pkg::text_cols);
               attr_addr <= attr_addr + chroni_pkg::vram_addr_t'(chroni_pkg::text_cols);
            end
            if (scan_left != '0) begin   // repeat of the current instruction
               scan_left <= scan_left - 1'b1;
               scan      <= scan + 1'b1;
               line_go   <= 1'b1;
            end else if (dl_op[3:0] == chroni_pkg::dl_end) begin
               line_go <= 1'b1;
            end else begin
               dl_state <= chroni_pkg::dl_read;
            end
         end
         case (dl_state)
            chroni_pkg::dl_read: begin
               dl_ptr   <= dl_ptr + 1'b1;
               dl_state <= chroni_pkg::dl_read_wait;
            end
            chroni_pkg::dl_read_wait: begin
               dl_op <= vram_data;
               if (vram_data[3:0] == chroni_pkg::dl_text && vram_data[chroni_pkg::dl_lms_bit]) begin
                  dl_ptr   <= dl_ptr + 1'b1;
                  lms_part <= '0;
                  dl_state <= chroni_pkg::dl_lms_read;
               end else begin
                  dl_state <= chroni_pkg::dl_exec;
               end
            end
            chroni_pkg::dl_lms_read: begin
               case (lms_part)
                  2'd0: row_addr[8:0]   <= {vram_data, 1'b0};
                  2'd1: row_addr[16:9]  <= vram_data;
                  2'd2: attr_addr[8:0]  <= {vram_data, 1'b0};
                  2'd3: attr_addr[16:9] <= vram_data;
               endcase
               lms_part <= lms_part + 1'b1;
               if (lms_part == 2'd3) begin
                  dl_state <= chroni_pkg::dl_exec;
               end else begin
                  dl_ptr <= dl_ptr + 1'b1;
               end
            end
            chroni_pkg::dl_exec: begin
               scan <= '0;
               if (dl_op[3:0] == chroni_pkg::dl_text) begin
                  scan_left <= chroni_pkg::scan_t'(chroni_pkg::font_rows - 1);
               end else if (dl_op[3:0] == chroni_pkg::dl_blank) begin
                  scan_left <= dl_op[6:4];
               end else begin
                  scan_left <= '0;
               end
               line_go  <= 1'b1;
               dl_state <= chroni_pkg::dl_wait;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         fd_state <= chroni_pkg::fd_idle;
         {col, glyph_load, text_done, glyph, attr, glyph_x} <= '0;
      end else if (frame_start) begin
         fd_state   <= chroni_pkg::fd_idle;
         glyph_load <= 1'b0;
         text_done  <= 1'b0;
      end else begin
         glyph_load <= 1'b0;
         text_done  <= 1'b0;
         case (fd_state)
            chroni_pkg::fd_idle:
               if (line_go && !line_blank) begin
                  col      <= '0;
                  fd_state <= scan == '0 ? chroni_pkg::fd_text_read : chroni_pkg::fd_font_fetch;
               end
            chroni_pkg::fd_text_read, chroni_pkg::fd_attr_read:
               if (col == chroni_pkg::text_cols) begin
                  col      <= '0;
                  fd_state <= fd_state == chroni_pkg::fd_text_read ?
                              chroni_pkg::fd_attr_read : chroni_pkg::fd_font_fetch;
               end else begin
                  col <= col + 1'b1;
               end
            chroni_pkg::fd_font_fetch:
               if (col != chroni_pkg::text_cols) begin
                  fd_state <= chroni_pkg::fd_font_wait;
               end else if (!shifter_busy && !glyph_load) begin   // last pixels drained
                  text_done <= 1'b1;
                  fd_state  <= chroni_pkg::fd_idle;
               end
            chroni_pkg::fd_font_wait: fd_state <= chroni_pkg::fd_font_write;
            chroni_pkg::fd_font_write:
               if (!shifter_busy) begin
                  glyph_load <= 1'b1;
                  glyph      <= vram_data;
                  attr       <= attr_q;
                  glyph_x    <= {col, 3'b000};
                  col        <= col + 1'b1;
                  fd_state   <= chroni_pkg::fd_font_fetch;
               end
            default: fd_state <= chroni_pkg::fd_idle;
         endcase
      end
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         line_busy <= 1'b0;
      end else if (frame_start || line_done) begin
         line_busy <= 1'b0;
      end else if (scanline_start) begin
         line_busy <= 1'b1;
      end
   end

   // the strobe source has to wait for line_done
   assert property (@(posedge sys_clk) disable iff (!rst_n) scanline_start |-> !line_busy);
   assert property (@(posedge sys_clk) disable iff (!rst_n) glyph_load |-> !shifter_busy);

endmodule

/* hdl/chroni_row_buffer.sv */
`timescale 1ns/1ps

module chroni_row_buffer (
   input  logic              sys_clk,
   input  logic              text_we,
   input  logic              attr_we,
   input  chroni_pkg::col_t  wr_col,
   input  chroni_pkg::byte_t wr_data,
   input  chroni_pkg::col_t  rd_col,
   output chroni_pkg::byte_t text_q,
   output chroni_pkg::byte_t attr_q
);

   chroni_pkg::byte_t text_mem [chroni_pkg::text_cols];
   chroni_pkg::byte_t attr_mem [chroni_pkg::text_cols];

   // both share the write column, only one strobe is active at a time
   always_ff @(posedge sys_clk) begin
      if (text_we) begin
         text_mem[wr_col] <= wr_data;
      end
      if (attr_we) begin
         attr_mem[wr_col] <= wr_data;
      end
      text_q <= text_mem[rd_col];
      attr_q <= attr_mem[rd_col];
   end

endmodule

/* hdl/chroni_vram.sv */
`timescale 1ns/1ps

module chroni_vram (
   input  logic                   sys_clk,
   input  chroni_pkg::vram_wr_t   vram_wr,
   input  chroni_pkg::vram_addr_t rd_addr,
   output chroni_pkg::byte_t      rd_data
);

   chroni_pkg::byte_t mem [2**$bits(chroni_pkg::vram_addr_t)];   // 128K bytes

   always_ff @(posedge sys_clk) begin
      if (vram_wr.en) begin
         mem[vram_wr.addr] <= vram_wr.data;
      end
      rd_data <= mem[rd_addr];   // controller side, one cycle latency
   end

endmodule

/* hdl/chroni_regs.sv */
`timescale 1ns/1ps

module chroni_regs (
   input  logic                 sys_clk,
   input  logic                 rst_n,
   input  logic [15:0]          cpu_addr,
   input  chroni_pkg::byte_t    cpu_wr_data,
   input  logic                 cpu_wr_en,
   output chroni_pkg::cfg_t     cfg,
   output chroni_pkg::vram_wr_t vram_wr,
   output chroni_pkg::pal_wr_t  pal_wr
);

   logic                   reg_wr;
   logic                   pal_hi;        // next data byte is the high half
   chroni_pkg::byte_t      pal_lo_byte;
   chroni_pkg::pal_index_t pal_index;
   chroni_pkg::vram_addr_t port_addr;

   assign reg_wr = cpu_wr_en && cpu_addr[15:7] == chroni_pkg::reg_base;

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg         <= '0;
         vram_wr     <= '0;
         pal_wr      <= '0;
         pal_hi      <= 1'b0;
         pal_lo_byte <= '0;
         pal_index   <= '0;
         port_addr   <= '0;
      end else begin
         vram_wr.en <= 1'b0;
         pal_wr.en  <= 1'b0;
         if (reg_wr) begin
            case (cpu_addr[6:0])
               chroni_pkg::reg_dl_lo:   cfg.dl_addr[8:0]  <= {cpu_wr_data, 1'b0};
               chroni_pkg::reg_dl_hi:   cfg.dl_addr[16:9] <= cpu_wr_data;
               chroni_pkg::reg_charset: cfg.charset       <= cpu_wr_data;
               chroni_pkg::reg_pal_index: begin
                  pal_index <= cpu_wr_data;
                  pal_hi    <= 1'b0;
               end
               chroni_pkg::reg_pal_data: begin
                  if (!pal_hi) begin
                     pal_lo_byte <= cpu_wr_data;
                  end else begin
                     pal_wr    <= '{en: 1'b1, index: pal_index, color: {cpu_wr_data, pal_lo_byte}};
                     pal_index <= pal_index + 1'b1;
                  end
                  pal_hi <= !pal_hi;
               end
               chroni_pkg::reg_vram_lo:  port_addr[7:0]  <= cpu_wr_data;
               chroni_pkg::reg_vram_mid: port_addr[15:8] <= cpu_wr_data;
               chroni_pkg::reg_vram_hi:  port_addr[16]   <= cpu_wr_data[0];
               chroni_pkg::reg_vram_data: begin
                  vram_wr   <= '{en: 1'b1, addr: port_addr, data: cpu_wr_data};
                  port_addr <= port_addr + 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   // the cpu never sends a palette byte in the cycle the finished entry is committed
   assert property (@(posedge sys_clk) disable iff (!rst_n)
      !(pal_wr.en && reg_wr && cpu_addr[6:0] == chroni_pkg::reg_pal_data));

endmodule

/* hdl/chroni_pkg.sv */
package chroni_pkg;

   typedef logic [16:0] vram_addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [5:0]  col_t;
   typedef logic [2:0]  scan_t;
   typedef logic [7:0]  pal_index_t;
   typedef logic [15:0] color_t;
   typedef logic [8:0]  pix_x_t;

   localparam logic [8:0] reg_base  = 9'h120;   // cpu 0x9000..0x907f
   localparam col_t       text_cols = 6'd40;
   localparam int         font_rows = 8;

   localparam logic [6:0] reg_dl_lo     = 7'h00;
   localparam logic [6:0] reg_dl_hi     = 7'h01;
   localparam logic [6:0] reg_charset   = 7'h02;
   localparam logic [6:0] reg_pal_index = 7'h04;
   localparam logic [6:0] reg_pal_data  = 7'h05;
   localparam logic [6:0] reg_vram_lo   = 7'h06;
   localparam logic [6:0] reg_vram_mid  = 7'h07;
   localparam logic [6:0] reg_vram_hi   = 7'h08;
   localparam logic [6:0] reg_vram_data = 7'h09;

   // display list opcodes live in bits 3:0
   localparam logic [3:0] dl_blank   = 4'd0;
   localparam logic [3:0] dl_end     = 4'd1;
   localparam logic [3:0] dl_text    = 4'd2;
   localparam int         dl_lms_bit = 6;

   typedef enum logic [2:0] {
      dl_idle, dl_read, dl_read_wait, dl_lms_read, dl_exec, dl_wait
   } dl_state_t;

   typedef enum logic [2:0] {
      fd_idle, fd_text_read, fd_attr_read, fd_font_fetch, fd_font_wait, fd_font_write
   } fetch_state_t;

   typedef struct packed {vram_addr_t dl_addr; byte_t charset;} cfg_t;
   typedef struct packed {logic en; vram_addr_t addr; byte_t data;} vram_wr_t;
   typedef struct packed {logic en; pal_index_t index; color_t color;} pal_wr_t;
   typedef struct packed {logic valid; pix_x_t x; pal_index_t index;} pix_index_t;
   typedef struct packed {logic valid; pix_x_t x; color_t color;} pix_color_t;

endpackage
